// ==== Bender.yml ====
package:
  name: conflict_serializer

sources:
  - include_dirs:
      - hw
    files:
      - hw/task_pkg.sv
      - hw/sched_pkg.sv
      - hw/task_intake.sv
      - hw/ready_list.sv
      - hw/core_dispatch.sv
      - hw/conflict_serializer.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_conflict_serializer.sv

// ==== files.f ====
+incdir+hw
hw/task_pkg.sv
hw/sched_pkg.sv
hw/task_intake.sv
hw/ready_list.sv
hw/core_dispatch.sv
hw/conflict_serializer.sv
tb/tb_conflict_serializer.sv

// ==== hw/conflict_serializer.sv ====
`timescale 1ns/1ps
`include "serializer_defines.svh"

module conflict_serializer (
   input  logic                                         clk,
   input  logic                                         rstn,
   input  logic                                         enq_valid,
   input  task_pkg::task_t                              enq_task,
   input  task_pkg::slot_t                              enq_slot,
   output logic                                         enq_ready,
   input  logic [`SER_NUM_CORES-1:0]                    core_req,
   input  task_pkg::task_type_t [`SER_NUM_CORES-1:0]    core_req_type,
   output logic [`SER_NUM_CORES-1:0]                    core_resp,
   output task_pkg::task_t                              resp_task,
   output task_pkg::slot_t                              resp_slot,
   input  logic                                         finish_valid,
   input  sched_pkg::core_id_t                          finish_core,
   output logic                                         almost_full,
   output logic                                         all_idle
);
   import task_pkg::*;
   import sched_pkg::*;

   enq_req_t                              enq_req;
   grant_t                                grant;
   release_t                              hint_release;
   logic [`SER_LIST_DEPTH-1:0]            entry_eligible;
   task_type_t [`SER_LIST_DEPTH-1:0]      entry_types;
   hint_t [`SER_LIST_DEPTH-1:0]           list_hints;
   logic [`SER_LIST_DEPTH-1:0]            list_valid;
   logic                                  list_empty;
   task_t                                 sel_task;
   slot_t                                 sel_slot;
   hint_t [`SER_NUM_CORES-1:0]            running_hints;
   logic [`SER_NUM_CORES-1:0]             hint_busy;

   task_intake i_task_intake (
      .clk, .rstn, .enq_valid, .enq_task, .enq_slot, .list_hints, .list_valid,
      .running_hints, .hint_busy, .grant, .enq_ready, .almost_full, .enq_req
   );

   ready_list i_ready_list (
      .clk, .rstn, .enq_req, .grant, .hint_release, .entry_eligible, .entry_types,
      .list_hints, .list_valid, .list_empty, .sel_task, .sel_slot
   );

   core_dispatch i_core_dispatch (
      .clk, .rstn, .core_req, .core_req_type, .finish_valid, .finish_core,
      .entry_eligible, .entry_types, .list_empty, .sel_task, .sel_slot,
      .core_resp, .resp_task, .resp_slot, .grant, .hint_release,
      .running_hints, .hint_busy, .all_idle
   );

endmodule

// ==== hw/core_dispatch.sv ====
`timescale 1ns/1ps
`include "serializer_defines.svh"

module core_dispatch (
   input  logic                                         clk,
   input  logic                                         rstn,
   input  logic [`SER_NUM_CORES-1:0]                    core_req,
   input  task_pkg::task_type_t [`SER_NUM_CORES-1:0]    core_req_type,
   input  logic                                         finish_valid,
   input  sched_pkg::core_id_t                          finish_core,
   input  logic [`SER_LIST_DEPTH-1:0]                   entry_eligible,
   input  task_pkg::task_type_t [`SER_LIST_DEPTH-1:0]   entry_types,
   input  logic                                         list_empty,
   input  task_pkg::task_t                              sel_task,
   input  task_pkg::slot_t                              sel_slot,
   output logic [`SER_NUM_CORES-1:0]                    core_resp,
   output task_pkg::task_t                              resp_task,
   output task_pkg::slot_t                              resp_slot,
   output sched_pkg::grant_t                            grant,
   output sched_pkg::release_t                          hint_release,
   output task_pkg::hint_t [`SER_NUM_CORES-1:0]         running_hints,
   output logic [`SER_NUM_CORES-1:0]                    hint_busy,
   output logic                                         all_idle
);
   import task_pkg::*;
   import sched_pkg::*;

   logic [(1 << `SER_TYPE_W)-1:0][`SER_LIST_DEPTH-1:0]  type_ready;
   logic [`SER_NUM_CORES-1:0]                           can_take;
   core_id_t                                            core_sel;
   list_idx_t                                           task_sel;
   hint_t [`SER_NUM_CORES-1:0]                          hints_q;
   logic [`SER_NUM_CORES-1:0]                           busy_q;
   logic                                                hint_clash;

   always_comb begin
      for (int t = 0; t < (1 << `SER_TYPE_W); t++) begin
         for (int j = 0; j < `SER_LIST_DEPTH; j++) begin
            type_ready[t][j] = entry_eligible[j] & (entry_types[j] == task_type_t'(t));
         end
      end
   end

   // a core served last cycle still holds its request, skip it
   always_comb begin
      for (int c = 0; c < `SER_NUM_CORES; c++) begin
         can_take[c] = core_req[c] & (|type_ready[core_req_type[c]])
                     & ~(grant.valid & (grant.core == core_id_t'(c)));
      end
   end

   // fixed priority, lowest core first, then oldest entry of its type
   always_comb begin
      core_sel = '0;
      for (int c = `SER_NUM_CORES-1; c >= 0; c--) begin
         if (can_take[c]) begin
            core_sel = core_id_t'(c);
         end
      end
      task_sel = '0;
      for (int j = `SER_LIST_DEPTH-1; j >= 0; j--) begin
         if (type_ready[core_req_type[core_sel]][j]) begin
            task_sel = list_idx_t'(j);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grant.valid <= 1'b0;
      end else begin
         grant.valid <= |can_take;
         grant.core  <= core_sel;
         // the list drops the previous grant at this edge
         if (grant.valid && (task_sel > grant.idx)) begin
            grant.idx <= task_sel - 1'b1;
         end else begin
            grant.idx <= task_sel;
         end
      end
   end

   always_comb begin
      for (int c = 0; c < `SER_NUM_CORES; c++) begin
         core_resp[c] = grant.valid & (grant.core == core_id_t'(c));
         hint_busy[c] = busy_q[c] & ~(finish_valid & (finish_core == core_id_t'(c)));
      end
   end

   assign resp_task = sel_task;
   assign resp_slot = sel_slot;

   // running-hint table, one entry per core
   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy_q <= '0;
      end else begin
         for (int c = 0; c < `SER_NUM_CORES; c++) begin
            if (core_resp[c]) begin
               busy_q[c] <= 1'b1;
            end else if (finish_valid && (finish_core == core_id_t'(c))) begin
               busy_q[c] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < `SER_NUM_CORES; c++) begin
         if (core_resp[c]) begin
            hints_q[c] <= sel_task.hint;
         end
      end
   end

   assign hint_release.valid = finish_valid & busy_q[finish_core];
   assign hint_release.hint  = hints_q[finish_core];
   assign running_hints      = hints_q;
   assign all_idle           = list_empty & ~(|busy_q);

   // two cores never run tasks with the same hint
   always_comb begin
      hint_clash = 1'b0;
      for (int c = 0; c < `SER_NUM_CORES; c++) begin
         for (int d = c + 1; d < `SER_NUM_CORES; d++) begin
            hint_clash |= busy_q[c] & busy_q[d] & (hints_q[c] == hints_q[d]);
         end
      end
   end

   a_hint_unique: assert property (@(posedge clk) disable iff (!rstn) !hint_clash);

endmodule

// ==== hw/ready_list.sv ====
`timescale 1ns/1ps
`include "serializer_defines.svh"

module ready_list (
   input  logic                                         clk,
   input  logic                                         rstn,
   input  sched_pkg::enq_req_t                          enq_req,
   input  sched_pkg::grant_t                            grant,
   input  sched_pkg::release_t                          hint_release,
   output logic [`SER_LIST_DEPTH-1:0]                   entry_eligible,
   output task_pkg::task_type_t [`SER_LIST_DEPTH-1:0]   entry_types,
   output task_pkg::hint_t [`SER_LIST_DEPTH-1:0]        list_hints,
   output logic [`SER_LIST_DEPTH-1:0]                   list_valid,
   output logic                                         list_empty,
   output task_pkg::task_t                              sel_task,
   output task_pkg::slot_t                              sel_slot
);
   import task_pkg::*;
   import sched_pkg::*;

   // entry 0 is the oldest task
   task_t [`SER_LIST_DEPTH-1:0]  tasks_q;
   slot_t [`SER_LIST_DEPTH-1:0]  slots_q;
   logic [`SER_LIST_DEPTH-1:0]   valid_q;
   logic [`SER_LIST_DEPTH-1:0]   conflict_q;

   // view of the list one place up, used when entries shift down
   task_t [`SER_LIST_DEPTH-1:0]  tasks_up;
   slot_t [`SER_LIST_DEPTH-1:0]  slots_up;
   logic [`SER_LIST_DEPTH-1:0]   valid_up;
   logic [`SER_LIST_DEPTH-1:0]   conflict_up;

   list_idx_t                    ins_idx;
   logic [`SER_LIST_DEPTH-1:0]   rel_match;
   logic [`SER_LIST_DEPTH-1:0]   rel_first;
   logic [`SER_LIST_DEPTH-1:0]   shift;
   logic [`SER_LIST_DEPTH-1:0]   take_new;

   // list stays packed, so the lowest free entry is the tail
   always_comb begin
      ins_idx = '0;
      for (int k = `SER_LIST_DEPTH-1; k >= 0; k--) begin
         if (!valid_q[k]) begin
            ins_idx = list_idx_t'(k);
         end
      end
   end

   // only the earliest waiter on the freed hint is unblocked
   always_comb begin
      for (int k = 0; k < `SER_LIST_DEPTH; k++) begin
         rel_match[k] = hint_release.valid & valid_q[k] & (tasks_q[k].hint == hint_release.hint);
      end
      rel_first = rel_match & ~(rel_match - 1'b1);
   end

   always_comb begin
      tasks_up[`SER_LIST_DEPTH-1]      = tasks_q[`SER_LIST_DEPTH-1];
      tasks_up[`SER_LIST_DEPTH-2:0]    = tasks_q[`SER_LIST_DEPTH-1:1];
      slots_up[`SER_LIST_DEPTH-1]      = slots_q[`SER_LIST_DEPTH-1];
      slots_up[`SER_LIST_DEPTH-2:0]    = slots_q[`SER_LIST_DEPTH-1:1];
      valid_up    = {1'b0, valid_q[`SER_LIST_DEPTH-1:1]};
      conflict_up = {1'b0, conflict_q[`SER_LIST_DEPTH-1:1] & ~rel_first[`SER_LIST_DEPTH-1:1]};
   end

   // with a removal in the same cycle the new task lands one place lower
   always_comb begin
      for (int i = 0; i < `SER_LIST_DEPTH; i++) begin
         shift[i]    = grant.valid & (i >= grant.idx);
         take_new[i] = enq_req.valid & (shift[i] ? (ins_idx == i + 1) : (ins_idx == i));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         valid_q    <= '0;
         conflict_q <= '0;
      end else begin
         for (int i = 0; i < `SER_LIST_DEPTH; i++) begin
            if (take_new[i]) begin
               valid_q[i]    <= 1'b1;
               conflict_q[i] <= enq_req.conflict;
            end else if (shift[i]) begin
               valid_q[i]    <= valid_up[i];
               conflict_q[i] <= conflict_up[i];
            end else if (rel_first[i]) begin
               conflict_q[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `SER_LIST_DEPTH; i++) begin
         if (take_new[i]) begin
            tasks_q[i] <= enq_req.new_task;
            slots_q[i] <= enq_req.slot;
         end else if (shift[i]) begin
            tasks_q[i] <= tasks_up[i];
            slots_q[i] <= slots_up[i];
         end
      end
   end

   // the entry granted last cycle is leaving and must not be picked again
   always_comb begin
      for (int k = 0; k < `SER_LIST_DEPTH; k++) begin
         entry_eligible[k] = valid_q[k] & ~conflict_q[k] & ~(grant.valid & (grant.idx == k));
         entry_types[k]    = tasks_q[k].ttype;
         list_hints[k]     = tasks_q[k].hint;
      end
   end

   assign list_valid = valid_q;
   assign list_empty = ~(|valid_q);
   assign sel_task   = tasks_q[grant.idx];
   assign sel_slot   = slots_q[grant.idx];

   // intake back-pressure must always leave a free entry
   a_insert_free: assert property (@(posedge clk) disable iff (!rstn)
      enq_req.valid |-> !valid_q[ins_idx]);

endmodule

// ==== hw/sched_pkg.sv ====
`include "serializer_defines.svh"

package sched_pkg;

   typedef logic [$clog2(`SER_NUM_CORES)-1:0] core_id_t;

   typedef logic [$clog2(`SER_LIST_DEPTH)-1:0] list_idx_t;

   // one insertion into the ready list
   typedef struct packed {
      logic            valid;
      task_pkg::task_t new_task;
      task_pkg::slot_t slot;
      logic            conflict;
   } enq_req_t;

   // registered dispatch decision, valid means the entry leaves the list this cycle
   typedef struct packed {
      logic      valid;
      core_id_t  core;
      list_idx_t idx;
   } grant_t;

   // hint freed by a finishing core
   typedef struct packed {
      logic            valid;
      task_pkg::hint_t hint;
   } release_t;

endpackage

// ==== hw/serializer_defines.svh ====
`ifndef SERIALIZER_DEFINES_SVH
`define SERIALIZER_DEFINES_SVH

// tile size
`define SER_NUM_CORES 4
`define SER_LIST_DEPTH 16

// task field widths
`define SER_TYPE_W 2
// top bit of the hint is the read-only bit
`define SER_HINT_W 32
`define SER_ARGS_W 32
`define SER_SLOT_W 7

// occupancy levels of the ready list
`define SER_ALMOST_FULL_LEVEL 12
// enq_ready falls here, two entries short of depth
`define SER_FULL_LEVEL 14

`endif

// ==== hw/task_intake.sv ====
`timescale 1ns/1ps
`include "serializer_defines.svh"

module task_intake (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  logic                                       enq_valid,
   input  task_pkg::task_t                            enq_task,
   input  task_pkg::slot_t                            enq_slot,
   input  task_pkg::hint_t [`SER_LIST_DEPTH-1:0]      list_hints,
   input  logic [`SER_LIST_DEPTH-1:0]                 list_valid,
   input  task_pkg::hint_t [`SER_NUM_CORES-1:0]       running_hints,
   input  logic [`SER_NUM_CORES-1:0]                  hint_busy,
   input  sched_pkg::grant_t                          grant,
   output logic                                       enq_ready,
   output logic                                       almost_full,
   output sched_pkg::enq_req_t                        enq_req
);
   import task_pkg::*;

   task_t                             clean_task;
   logic [`SER_LIST_DEPTH-1:0]        list_hit;
   logic [`SER_NUM_CORES-1:0]         run_hit;
   logic [$clog2(`SER_LIST_DEPTH):0]  occupancy;

   // a read-only task must still serialize against writers of the same key
   always_comb begin
      clean_task = enq_task;
      clean_task.hint[`SER_HINT_W-1] = 1'b0;
   end

   // compare against waiting tasks and against tasks still running
   always_comb begin
      for (int k = 0; k < `SER_LIST_DEPTH; k++) begin
         list_hit[k] = list_valid[k] & (list_hints[k] == clean_task.hint);
      end
      for (int c = 0; c < `SER_NUM_CORES; c++) begin
         run_hit[c] = hint_busy[c] & (running_hints[c] == clean_task.hint);
      end
   end

   always_comb begin
      enq_req.valid    = enq_valid & enq_ready;
      enq_req.new_task = clean_task;
      enq_req.slot     = enq_slot;
      enq_req.conflict = (|list_hit) | (|run_hit);
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         occupancy <= '0;
      end else begin
         case ({enq_req.valid, grant.valid})
            2'b10: occupancy <= occupancy + 1'b1;
            2'b01: occupancy <= occupancy - 1'b1;
            default: ;
         endcase
      end
   end

   assign enq_ready   = (occupancy < `SER_FULL_LEVEL);
   assign almost_full = (occupancy >= `SER_ALMOST_FULL_LEVEL);

   a_occupancy_bound: assert property (@(posedge clk) disable iff (!rstn)
      occupancy <= `SER_LIST_DEPTH);

endmodule

// ==== hw/task_pkg.sv ====
`include "serializer_defines.svh"

package task_pkg;

   // task type, selects which cores may run the task
   typedef logic [`SER_TYPE_W-1:0] task_type_t;

   // conflict key, tasks with equal hints never run together
   typedef logic [`SER_HINT_W-1:0] hint_t;

   // opaque payload handed to the core
   typedef logic [`SER_ARGS_W-1:0] args_t;

   // commit-queue slot the task came from
   typedef logic [`SER_SLOT_W-1:0] slot_t;

   // task as seen by the cores, 66 bits
   typedef struct packed {
      task_type_t ttype;
      hint_t      hint;
      args_t      args;
   } task_t;

endpackage

// ==== tb/tb_conflict_serializer.sv ====
`timescale 1ns/1ps
`include "serializer_defines.svh"

module tb_conflict_serializer;
   import task_pkg::*;
   import sched_pkg::*;

   logic                                clk;
   logic                                rstn;
   logic                                enq_valid;
   logic                                enq_ready;
   task_t                               enq_task;
   slot_t                               enq_slot;
   logic [`SER_NUM_CORES-1:0]           core_req;
   task_type_t [`SER_NUM_CORES-1:0]     core_req_type;
   logic [`SER_NUM_CORES-1:0]           core_resp;
   task_t                               resp_task;
   slot_t                               resp_slot;
   logic                                finish_valid;
   core_id_t                            finish_core;
   logic                                almost_full;
   logic                                all_idle;
   logic [31:0]                         lcg_state;
   slot_t                               next_slot;
   task_t                               got_task;
   int                                  err_count;

   // reference model of waiting tasks and running hints
   task_t                               wait_tasks[$];
   slot_t                               wait_slots[$];
   hint_t                               run_hint[`SER_NUM_CORES];
   bit                                  run_busy[`SER_NUM_CORES];

   conflict_serializer i_conflict_serializer (
      .clk, .rstn, .enq_valid, .enq_task, .enq_slot, .enq_ready, .core_req, .core_req_type,
      .core_resp, .resp_task, .resp_slot, .finish_valid, .finish_core, .almost_full, .all_idle
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic stop_run();
      err_count++;
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic flag_mismatch(string msg);
      $display("Mismatch at %0t: %s", $time, msg);
      stop_run();
   endtask

   task automatic timeout_abort(string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      stop_run();
   endtask

   // earliest task of the type whose key is neither running nor held by an older waiter
   function automatic int expected_index(task_type_t t);
      bit blocked;
      for (int i = 0; i < wait_tasks.size(); i++) begin
         blocked = 1'b0;
         for (int c = 0; c < `SER_NUM_CORES; c++) begin
            if (run_busy[c] && run_hint[c] == wait_tasks[i].hint) begin
               blocked = 1'b1;
            end
         end
         for (int j = 0; j < i; j++) begin
            if (wait_tasks[j].hint == wait_tasks[i].hint) begin
               blocked = 1'b1;
            end
         end
         if (!blocked && wait_tasks[i].ttype == t) begin
            return i;
         end
      end
      return -1;
   endfunction

   task automatic enqueue(task_type_t t, hint_t h);
      task_t tk;
      int    n;
      tk.ttype  = t;
      tk.hint   = h;
      tk.args   = next_rand();
      enq_valid = 1'b1;
      enq_task  = tk;
      enq_slot  = next_slot;
      n = 0;
      while (!enq_ready) begin
         step();
         n++;
         if (n > 100) timeout_abort("enq_ready");
      end
      step();
      enq_valid = 1'b0;
      // the serializer stores the key with the read-only bit cleared
      tk.hint[`SER_HINT_W-1] = 1'b0;
      wait_tasks.push_back(tk);
      wait_slots.push_back(next_slot);
      next_slot++;
   endtask

   task automatic request_start(int c, task_type_t t);
      core_req[c]      = 1'b1;
      core_req_type[c] = t;
   endtask

   task automatic await_response(int c);
      int n;
      int idx;
      n = 0;
      step();
      while (core_resp == '0) begin
         n++;
         if (n > 100) timeout_abort($sformatf("a response to core %0d", c));
         step();
      end
      idx = expected_index(core_req_type[c]);
      assert (core_resp == (1 << c))
         else flag_mismatch($sformatf("core_resp %b, expected core %0d", core_resp, c));
      assert (idx >= 0) else flag_mismatch("response while no task is eligible");
      assert (resp_task == wait_tasks[idx])
         else flag_mismatch($sformatf("task %h, expected %h", resp_task, wait_tasks[idx]));
      assert (resp_slot == wait_slots[idx])
         else flag_mismatch($sformatf("slot %0d, expected %0d", resp_slot, wait_slots[idx]));
      got_task    = resp_task;
      core_req[c] = 1'b0;
      run_hint[c] = wait_tasks[idx].hint;
      run_busy[c] = 1'b1;
      wait_tasks.delete(idx);
      wait_slots.delete(idx);
   endtask

   task automatic finish_task(int c);
      // the task starts running at the edge that ends the response cycle
      step();
      finish_valid = 1'b1;
      finish_core  = core_id_t'(c);
      step();
      finish_valid = 1'b0;
      run_busy[c]  = 1'b0;
   endtask

   task automatic quiet_window(int cycles);
      repeat (cycles) begin
         step();
         assert (core_resp == '0)
            else flag_mismatch($sformatf("core_resp %b while blocked", core_resp));
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (!all_idle) begin
         step();
         n++;
         if (n > 100) timeout_abort("all_idle");
      end
   endtask

   // serve the oldest waiting task one at a time until the list is empty
   task automatic drain();
      while (wait_tasks.size() > 0) begin
         request_start(0, wait_tasks[0].ttype);
         await_response(0);
         finish_task(0);
      end
      wait_idle();
   endtask

   task automatic check_reset();
      step();
      assert (core_resp == '0) else flag_mismatch("core_resp not zero after reset");
      assert (enq_ready && all_idle) else flag_mismatch("enq_ready or all_idle low after reset");
      assert (!almost_full) else flag_mismatch("almost_full high after reset");
   endtask

   task automatic single_task();
      task_type_t t;
      t = task_type_t'(next_rand());
      enqueue(t, next_rand());
      assert (!all_idle) else flag_mismatch("all_idle high with a waiting task");
      request_start(2, t);
      await_response(2);
      finish_task(2);
      wait_idle();
   endtask

   // two tasks on one key, the second must wait for the first to finish
   task automatic conflict_pair(bit read_only);
      hint_t key;
      key = next_rand();
      key[`SER_HINT_W-1] = 1'b0;
      enqueue(2'd1, {read_only, key[`SER_HINT_W-2:0]});
      enqueue(2'd1, key);
      request_start(0, 2'd1);
      await_response(0);
      assert (got_task.hint[`SER_HINT_W-1] == 1'b0)
         else flag_mismatch("read-only bit not cleared");
      request_start(1, 2'd1);
      quiet_window(20);
      finish_task(0);
      await_response(1);
      finish_task(1);
      wait_idle();
   endtask

   task automatic type_order();
      enqueue(2'd0, next_rand());
      enqueue(2'd1, next_rand());
      enqueue(2'd2, next_rand());
      enqueue(2'd1, next_rand());
      enqueue(2'd0, next_rand());
      enqueue(2'd2, next_rand());
      request_start(3, 2'd2);
      await_response(3);
      request_start(1, 2'd1);
      await_response(1);
      finish_task(3);
      finish_task(1);
      drain();
   endtask

   task automatic back_pressure();
      int n;
      for (int i = 1; i <= `SER_FULL_LEVEL; i++) begin
         enqueue(2'd0, next_rand());
         assert (almost_full == (i >= `SER_ALMOST_FULL_LEVEL))
            else flag_mismatch($sformatf("almost_full %b at occupancy %0d", almost_full, i));
         assert (enq_ready == (i < `SER_FULL_LEVEL))
            else flag_mismatch($sformatf("enq_ready %b at occupancy %0d", enq_ready, i));
      end
      repeat (5) begin
         step();
         assert (!enq_ready) else flag_mismatch("enq_ready rose without a dispatch");
      end
      request_start(0, 2'd0);
      await_response(0);
      n = 0;
      while (!enq_ready) begin
         step();
         n++;
         if (n > 10) timeout_abort("enq_ready after a dispatch");
      end
      finish_task(0);
      drain();
   endtask

   initial begin
      clk           = 1'b0;
      rstn          = 1'b0;
      enq_valid     = 1'b0;
      enq_task      = '0;
      enq_slot      = '0;
      core_req      = '0;
      core_req_type = '0;
      finish_valid  = 1'b0;
      finish_core   = '0;
      lcg_state     = 32'hab89b0f8;
      next_slot     = '0;
      err_count     = 0;
      repeat (2) @(posedge clk);
      #1 rstn = 1'b1;
      check_reset();
      single_task();
      conflict_pair(1'b0);
      type_order();
      back_pressure();
      conflict_pair(1'b1);
      if (err_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
